// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width.
`define CORE_XLEN 32

// Register file size and the width of a register address.
`define CORE_REG_COUNT 32
`define CORE_REG_AW 5

// First fetch address and the word that an empty stage holds.
`define CORE_RESET_PC 32'h0000_0000
`define CORE_NOP_WORD 32'h0000_0000

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // Primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function codes under OP_SPECIAL.
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } instr_r_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    // One instruction word seen either as R-format or as I-format.
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    // ALU operation carried from decode to execute.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

    // Data bus access done in the memory stage.
    // A load takes its register value from the bus instead of the ALU.
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we_i,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i,
    input  logic [`CORE_REG_AW-1:0] raddr1_i,
    input  logic [`CORE_REG_AW-1:0] raddr2_i,
    output logic [`CORE_XLEN-1:0]   rdata1_o,
    output logic [`CORE_XLEN-1:0]   rdata2_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Register 0 reads as zero whatever the array holds.
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  isa_pkg::instr_u         inst_i,
    output logic [`CORE_REG_AW-1:0] rs_o,
    output logic [`CORE_REG_AW-1:0] rt_o,
    output logic [`CORE_REG_AW-1:0] dest_o,
    output logic [`CORE_XLEN-1:0]   imm_o,
    output logic                    use_imm_o,
    output pipe_pkg::alu_op_e       alu_op_o,
    output pipe_pkg::mem_op_e       mem_op_o,
    output logic                    reg_we_o
);

    logic [`CORE_XLEN-1:0] imm_sext;
    logic [`CORE_XLEN-1:0] imm_zext;
    logic                  we;

    assign rs_o     = inst_i.i.rs;
    assign rt_o     = inst_i.i.rt;
    assign imm_sext = {{(`CORE_XLEN-16){inst_i.i.imm[15]}}, inst_i.i.imm};
    assign imm_zext = {{(`CORE_XLEN-16){1'b0}}, inst_i.i.imm};

    always_comb begin
        dest_o    = inst_i.i.rt;
        imm_o     = imm_sext;
        use_imm_o = 1'b1;
        alu_op_o  = pipe_pkg::ALU_ADD;
        mem_op_o  = pipe_pkg::MEM_NONE;
        we        = 1'b0;
        case (inst_i.r.opcode)
            isa_pkg::OP_SPECIAL: begin
                dest_o    = inst_i.r.rd;
                use_imm_o = 1'b0;
                we        = 1'b1;
                case (inst_i.r.funct)
                    isa_pkg::FN_ADDU: alu_op_o = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op_o = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op_o = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op_o = pipe_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  alu_op_o = pipe_pkg::ALU_SLT;
                    // Unknown function codes, the all-zero word among them.
                    default:          we = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: we = 1'b1;
            isa_pkg::OP_ORI: begin
                imm_o    = imm_zext;
                alu_op_o = pipe_pkg::ALU_OR;
                we       = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                imm_o    = imm_zext;
                alu_op_o = pipe_pkg::ALU_LUI;
                we       = 1'b1;
            end
            isa_pkg::OP_LW: begin
                mem_op_o = pipe_pkg::MEM_LOAD;
                we       = 1'b1;
            end
            isa_pkg::OP_SW: mem_op_o = pipe_pkg::MEM_STORE;
            default: we = 1'b0;
        endcase
    end

    // Writes to register 0 are dropped here, so no later stage forwards them.
    assign reg_we_o = we && (dest_o != '0);

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module operand_forward (
    input  logic [`CORE_REG_AW-1:0] addr_i,
    input  logic [`CORE_XLEN-1:0]   regs_val_i,
    input  logic [`CORE_REG_AW-1:0] ex_addr_i,
    input  logic                    ex_we_i,
    input  pipe_pkg::mem_op_e       ex_mem_op_i,
    input  logic [`CORE_XLEN-1:0]   ex_val_i,
    input  logic [`CORE_REG_AW-1:0] mm_addr_i,
    input  logic                    mm_we_i,
    input  logic [`CORE_XLEN-1:0]   mm_val_i,
    input  logic [`CORE_REG_AW-1:0] wb_addr_i,
    input  logic                    wb_we_i,
    input  logic [`CORE_XLEN-1:0]   wb_val_i,
    output logic [`CORE_XLEN-1:0]   val_o
);

    // The youngest writer wins. A load still in EX has no data yet.
    always_comb begin
        if (addr_i == '0) begin
            val_o = regs_val_i;
        end else if (ex_we_i && ex_addr_i == addr_i && ex_mem_op_i != pipe_pkg::MEM_LOAD) begin
            val_o = ex_val_i;
        end else if (mm_we_i && mm_addr_i == addr_i) begin
            val_o = mm_val_i;
        end else if (wb_we_i && wb_addr_i == addr_i) begin
            val_o = wb_val_i;
        end else begin
            val_o = regs_val_i;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  pipe_pkg::alu_op_e     alu_op_i,
    input  logic [`CORE_XLEN-1:0] a_i,
    input  logic [`CORE_XLEN-1:0] b_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  logic                  use_imm_i,
    output logic [`CORE_XLEN-1:0] result_o
);

    logic [`CORE_XLEN-1:0] op_b;
    logic                  less;

    assign op_b = use_imm_i ? imm_i : b_i;
    assign less = $signed(a_i) < $signed(op_b);

    // All arithmetic wraps. Loads and stores come through as ALU_ADD,
    // so the result is their bus address.
    always_comb begin
        case (alu_op_i)
            pipe_pkg::ALU_ADD: begin
                result_o = a_i + op_b;
            end
            pipe_pkg::ALU_SUB: begin
                result_o = a_i - op_b;
            end
            pipe_pkg::ALU_AND: begin
                result_o = a_i & op_b;
            end
            pipe_pkg::ALU_OR: begin
                result_o = a_i | op_b;
            end
            pipe_pkg::ALU_SLT: begin
                result_o = {{(`CORE_XLEN-1){1'b0}}, less};
            end
            pipe_pkg::ALU_LUI: begin
                result_o = {op_b[`CORE_XLEN/2-1:0], {(`CORE_XLEN/2){1'b0}}};
            end
            default: begin
                result_o = a_i + op_b;
            end
        endcase
    end

endmodule

// ==== hw/mini_mips_core.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module mini_mips_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`CORE_XLEN-1:0] ibus_addr_o,
    input  logic [`CORE_XLEN-1:0] ibus_rdata_i,
    output logic [`CORE_XLEN-1:0] dbus_addr_o,
    output logic [`CORE_XLEN-1:0] dbus_wdata_o,
    output logic                  dbus_rd_o,
    output logic                  dbus_wr_o,
    input  logic [`CORE_XLEN-1:0] dbus_rdata_i
);

    logic [`CORE_XLEN-1:0]   pc;
    logic                    stall;

    isa_pkg::instr_u         id_inst;
    logic [`CORE_REG_AW-1:0] id_rs, id_rt, id_dest;
    logic [`CORE_XLEN-1:0]   id_imm, id_rs_reg, id_rt_reg, id_rs_val, id_rt_val;
    logic                    id_use_imm, id_we, id_rt_read;
    pipe_pkg::alu_op_e       id_alu_op;
    pipe_pkg::mem_op_e       id_mem_op;

    pipe_pkg::alu_op_e       ex_alu_op;
    pipe_pkg::mem_op_e       ex_mem_op;
    logic [`CORE_XLEN-1:0]   ex_a, ex_b, ex_imm, ex_result;
    logic [`CORE_REG_AW-1:0] ex_dest;
    logic                    ex_use_imm, ex_we;

    pipe_pkg::mem_op_e       mm_mem_op;
    logic [`CORE_XLEN-1:0]   mm_result, mm_wdata, mm_val;
    logic [`CORE_REG_AW-1:0] mm_dest;
    logic                    mm_we;

    logic [`CORE_XLEN-1:0]   wb_val;
    logic [`CORE_REG_AW-1:0] wb_dest;
    logic                    wb_we;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and hazard detection
    ////////////////////////////////////////////////////////////////////////////

    assign ibus_addr_o = pc;

    // Only R-format words and stores read rt as a source.
    assign id_rt_read = !id_use_imm || (id_mem_op == pipe_pkg::MEM_STORE);

    // A load in EX cannot forward yet, so the consumer waits one cycle.
    assign stall = (ex_mem_op == pipe_pkg::MEM_LOAD) && ex_we && (ex_dest != '0) &&
                   ((ex_dest == id_rs) || (id_rt_read && (ex_dest == id_rt)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `CORE_RESET_PC;
            id_inst <= `CORE_NOP_WORD;
        end else if (!stall) begin
            pc      <= pc + `CORE_XLEN'd4;
            id_inst <= ibus_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    decode_stage u_decode (
        .inst_i    (id_inst),
        .rs_o      (id_rs),
        .rt_o      (id_rt),
        .dest_o    (id_dest),
        .imm_o     (id_imm),
        .use_imm_o (id_use_imm),
        .alu_op_o  (id_alu_op),
        .mem_op_o  (id_mem_op),
        .reg_we_o  (id_we)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (wb_we),
        .waddr_i  (wb_dest),
        .wdata_i  (wb_val),
        .raddr1_i (id_rs),
        .raddr2_i (id_rt),
        .rdata1_o (id_rs_reg),
        .rdata2_o (id_rt_reg)
    );

    operand_forward u_fwd_s (
        .addr_i (id_rs), .regs_val_i (id_rs_reg),
        .ex_addr_i (ex_dest), .ex_we_i (ex_we), .ex_mem_op_i (ex_mem_op), .ex_val_i (ex_result),
        .mm_addr_i (mm_dest), .mm_we_i (mm_we), .mm_val_i (mm_val),
        .wb_addr_i (wb_dest), .wb_we_i (wb_we), .wb_val_i (wb_val),
        .val_o (id_rs_val)
    );

    operand_forward u_fwd_t (
        .addr_i (id_rt), .regs_val_i (id_rt_reg),
        .ex_addr_i (ex_dest), .ex_we_i (ex_we), .ex_mem_op_i (ex_mem_op), .ex_val_i (ex_result),
        .mm_addr_i (mm_dest), .mm_we_i (mm_we), .mm_val_i (mm_val),
        .wb_addr_i (wb_dest), .wb_we_i (wb_we), .wb_val_i (wb_val),
        .val_o (id_rt_val)
    );

    // A stall turns the ID/EX slot into a bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || stall) begin
            ex_we     <= 1'b0;
            ex_mem_op <= pipe_pkg::MEM_NONE;
        end else begin
            ex_we     <= id_we;
            ex_mem_op <= id_mem_op;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op  <= id_alu_op;
        ex_a       <= id_rs_val;
        ex_b       <= id_rt_val;
        ex_imm     <= id_imm;
        ex_use_imm <= id_use_imm;
        ex_dest    <= id_dest;
    end

    execute_stage u_exec (
        .alu_op_i  (ex_alu_op),
        .a_i       (ex_a),
        .b_i       (ex_b),
        .imm_i     (ex_imm),
        .use_imm_i (ex_use_imm),
        .result_o  (ex_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory access and writeback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_we     <= 1'b0;
            mm_mem_op <= pipe_pkg::MEM_NONE;
            wb_we     <= 1'b0;
        end else begin
            mm_we     <= ex_we;
            mm_mem_op <= ex_mem_op;
            wb_we     <= mm_we;
        end
    end

    always_ff @(posedge clk) begin
        mm_result <= ex_result;
        mm_wdata  <= ex_b;
        mm_dest   <= ex_dest;
        wb_val    <= mm_val;
        wb_dest   <= mm_dest;
    end

    assign dbus_addr_o  = mm_result;
    assign dbus_wdata_o = mm_wdata;
    assign dbus_rd_o    = (mm_mem_op == pipe_pkg::MEM_LOAD);
    assign dbus_wr_o    = (mm_mem_op == pipe_pkg::MEM_STORE);
    assign mm_val       = dbus_rd_o ? dbus_rdata_i : mm_result;

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset is released on a falling edge, after 4 full cycles.
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verification/tb_mini_mips.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_mini_mips;

    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic                  clk;
    logic                  rst_n;
    logic [`CORE_XLEN-1:0] ibus_addr;
    logic [`CORE_XLEN-1:0] ibus_rdata;
    logic [`CORE_XLEN-1:0] dbus_addr;
    logic [`CORE_XLEN-1:0] dbus_wdata;
    logic [`CORE_XLEN-1:0] dbus_rdata;
    logic                  dbus_rd;
    logic                  dbus_wr;

    logic [`CORE_XLEN-1:0] prog[$];
    logic [`CORE_XLEN-1:0] exp_addr[$];
    logic [`CORE_XLEN-1:0] exp_data[$];
    logic [`CORE_XLEN-1:0] exp_load_addr[$];
    logic [`CORE_XLEN-1:0] dmem [16];
    int                    n_stores;
    int                    n_loads;
    int                    cycles;
    int                    limit;
    integer                seed;

    tb_clock_gen u_clk (.clk_o (clk), .rst_n_o (rst_n));

    mini_mips_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_addr_o  (ibus_addr),
        .ibus_rdata_i (ibus_rdata),
        .dbus_addr_o  (dbus_addr),
        .dbus_wdata_o (dbus_wdata),
        .dbus_rd_o    (dbus_rd),
        .dbus_wr_o    (dbus_wr),
        .dbus_rdata_i (dbus_rdata)
    );

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic expect_load(input logic [31:0] addr);
        exp_load_addr.push_back(addr);
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program and expected stores
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_program();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        // Constants that check sign extension, zero extension and upper-half placement.
        emit(encode_i(OP_ADDIU, 5'd0, 5'd1, 16'hfff0));
        emit(encode_i(OP_ORI, 5'd0, 5'd2, 16'h8001));
        emit(encode_i(OP_LUI, 5'd0, 5'd3, 16'h1234));
        emit(encode_i(OP_SW, 5'd0, 5'd1, 16'd0));
        emit(encode_i(OP_SW, 5'd0, 5'd2, 16'd4));
        emit(encode_i(OP_SW, 5'd0, 5'd3, 16'd8));
        expect_store(0, 32'hffff_fff0);
        expect_store(4, 32'h0000_8001);
        expect_store(8, 32'h1234_0000);
        // Dependent ALU words consumed from EX, MM and WB.
        emit(encode_r(5'd2, 5'd3, 5'd4, FN_ADDU));
        emit(encode_r(5'd4, 5'd1, 5'd5, FN_SUBU));
        emit(encode_i(OP_SW, 5'd0, 5'd5, 16'd12));
        emit(encode_i(OP_SW, 5'd0, 5'd4, 16'd16));
        emit(encode_i(OP_SW, 5'd0, 5'd5, 16'd20));
        emit(encode_r(5'd3, 5'd2, 5'd6, FN_SUBU));
        emit(encode_r(5'd6, 5'd6, 5'd7, FN_ADDU));
        emit(encode_i(OP_SW, 5'd0, 5'd6, 16'd24));
        emit(encode_i(OP_SW, 5'd0, 5'd7, 16'd28));
        expect_store(12, 32'h1234_8011);
        expect_store(16, 32'h1234_8001);
        expect_store(20, 32'h1234_8011);
        expect_store(24, 32'h1233_7fff);
        expect_store(28, 32'h2466_fffe);
        // Load-use through memory.
        emit(encode_i(OP_SW, 5'd0, 5'd7, 16'd32));
        emit(encode_i(OP_LW, 5'd0, 5'd8, 16'd32));
        emit(encode_r(5'd8, 5'd1, 5'd9, FN_ADDU));
        emit(encode_i(OP_SW, 5'd0, 5'd9, 16'd36));
        expect_store(32, 32'h2466_fffe);
        expect_load(32);
        expect_store(36, 32'h2466_ffee);
        // Logic and signed compare.
        emit(encode_i(OP_ADDIU, 5'd0, 5'd10, 16'hfffd));
        emit(encode_i(OP_ADDIU, 5'd0, 5'd11, 16'd6));
        emit(encode_r(5'd10, 5'd11, 5'd12, FN_AND));
        emit(encode_r(5'd10, 5'd11, 5'd13, FN_OR));
        emit(encode_r(5'd10, 5'd11, 5'd14, FN_SLT));
        emit(encode_r(5'd11, 5'd10, 5'd15, FN_SLT));
        emit(encode_i(OP_SW, 5'd0, 5'd12, 16'd40));
        emit(encode_i(OP_SW, 5'd0, 5'd13, 16'd44));
        emit(encode_i(OP_SW, 5'd0, 5'd14, 16'd48));
        emit(encode_i(OP_SW, 5'd0, 5'd15, 16'd52));
        expect_store(40, 32'h0000_0004);
        expect_store(44, 32'hffff_ffff);
        expect_store(48, 32'h0000_0001);
        expect_store(52, 32'h0000_0000);
        // Register 0 stays zero.
        emit(encode_i(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        emit(encode_i(OP_LW, 5'd0, 5'd0, 16'd0));
        emit(encode_i(OP_SW, 5'd0, 5'd0, 16'd56));
        expect_load(0);
        expect_store(56, 32'h0000_0000);
        // An undefined opcode aimed at $1 between two stores.
        emit(encode_i(OP_SW, 5'd0, 5'd1, 16'd60));
        emit(encode_i(6'h3f, 5'd0, 5'd1, 16'h0040));
        emit(encode_i(OP_SW, 5'd0, 5'd1, 16'd0));
        expect_store(60, 32'hffff_fff0);
        expect_store(0, 32'hffff_fff0);
        // Random immediates summed by two chained ADDIU words.
        for (int k = 0; k < 3; k++) begin
            imm_a = 16'($random(seed));
            imm_b = 16'($random(seed));
            emit(encode_i(OP_ADDIU, 5'd0, 5'd16, imm_a));
            emit(encode_i(OP_ADDIU, 5'd16, 5'd17, imm_b));
            emit(encode_i(OP_SW, 5'd0, 5'd17, 16'(4 * k)));
            expect_store(4 * k, sign_extend(imm_a) + sign_extend(imm_b));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus models and store checks
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if ((ibus_addr >> 2) < prog.size()) begin
            ibus_rdata = prog[ibus_addr >> 2];
        end else begin
            ibus_rdata = `CORE_NOP_WORD;
        end
        dbus_rdata = dmem[dbus_addr[5:2]];
    end

    always @(posedge clk) begin
        if (dbus_rd) begin
            assert (n_loads < exp_load_addr.size()) else begin
                $display("A load from %h at %0t ns has no entry left in the check table",
                         dbus_addr, $time);
                abort_run();
            end
            assert (dbus_addr === exp_load_addr[n_loads]) else begin
                $display("Fail at %0t ns: load %0d read from %h, expected %h",
                         $time, n_loads, dbus_addr, exp_load_addr[n_loads]);
                abort_run();
            end
            n_loads++;
        end
        if (dbus_wr) begin
            assert (n_stores < exp_addr.size()) else begin
                $display("A store to %h at %0t ns has no entry left in the check table",
                         dbus_addr, $time);
                abort_run();
            end
            assert (dbus_addr === exp_addr[n_stores] && dbus_wdata === exp_data[n_stores])
            else begin
                $display("Fail at %0t ns: store %0d wrote %h to %h, expected %h to %h",
                         $time, n_stores, dbus_wdata, dbus_addr,
                         exp_data[n_stores], exp_addr[n_stores]);
                abort_run();
            end
            dmem[dbus_addr[5:2]] = dbus_wdata;
            n_stores++;
        end
    end

    initial begin
        ibus_rdata = `CORE_NOP_WORD;
        dbus_rdata = '0;
        n_stores   = 0;
        n_loads    = 0;
        cycles     = 0;
        seed       = 32'hf526d051;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = 32'hd0d0_0000 | (i << 2);
        end
        build_program();
        limit = 4 * prog.size() + 20;
        @(posedge rst_n);
        // The last store has left MM once the PC runs 4 words past the program.
        while (ibus_addr < 4 * (prog.size() + 4)) begin
            @(negedge clk);
            cycles++;
            assert (cycles < limit) else begin
                $display("Timeout: the program did not finish within %0d cycles", limit);
                abort_run();
            end
        end
        assert (n_stores == exp_addr.size() && n_loads == exp_load_addr.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Only %0d of %0d expected stores and %0d of %0d expected loads were seen",
                     n_stores, exp_addr.size(), n_loads, exp_load_addr.size());
            abort_run();
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/operand_forward.sv
hw/execute_stage.sv
hw/mini_mips_core.sv
verification/tb_clock_gen.sv
verification/tb_mini_mips.sv
